//--- hw/shannon_lpf_settings.svh
`ifndef SHANNON_LPF_SETTINGS_SVH
`define SHANNON_LPF_SETTINGS_SVH

// Block geometry
`define LPF_NSAMPS      8
`define LPF_HIST_BLOCKS 5
`define LPF_NPAIRS      8

// Data widths
`define LPF_IN_BITS     12
`define LPF_OUT_BITS    12
`define LPF_COEF_BITS   18

// Output scaling and pipeline depth
`define LPF_SHIFT       15
`define LPF_LATENCY     5

// Q0.15 taps, symmetric about lag 16
`define LPF_COEF_L1     (-23)
`define LPF_COEF_L3     (105)
`define LPF_COEF_L5     (-526)
`define LPF_COEF_L7     (263)
`define LPF_COEF_L9     (-949)
`define LPF_COEF_L11    (1672)
`define LPF_COEF_L13    (-3216)
`define LPF_COEF_L15    (10342)
`define LPF_COEF_CENTRE (16384)

`endif

//--- hw/shannon_lpf_pkg.sv
`default_nettype none

`include "shannon_lpf_settings.svh"

package shannon_lpf_pkg;

    // Input side
    typedef logic signed [`LPF_IN_BITS-1:0] sample_t;

    // Lane 0 is the oldest sample of the block
    typedef sample_t [`LPF_NSAMPS-1:0] sample_block_t;

    // Current block on top, older blocks below
    typedef sample_t [`LPF_HIST_BLOCKS*`LPF_NSAMPS-1:0] hist_window_t;

    // Arithmetic widths
    typedef logic signed [`LPF_IN_BITS:0] pair_sum_t;
    typedef logic signed [`LPF_COEF_BITS-1:0] coef_t;
    typedef logic signed [`LPF_IN_BITS+`LPF_COEF_BITS:0] product_t;

    // Nine products plus headroom
    typedef logic signed [`LPF_IN_BITS+`LPF_COEF_BITS+5:0] acc_t;

    // Output side
    typedef logic signed [`LPF_OUT_BITS-1:0] out_sample_t;
    typedef out_sample_t [`LPF_NSAMPS-1:0] out_block_t;

    // Pair j holds lags 2j+1 and 31-2j
    typedef struct packed {
        pair_sum_t [`LPF_NPAIRS-1:0] pairs;
        pair_sum_t                   centre;
    } lane_terms_t;

endpackage

`default_nettype wire

//--- hw/sample_history.sv
`timescale 1ns/1ps
`default_nettype none

`include "shannon_lpf_settings.svh"

module sample_history (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  shannon_lpf_pkg::sample_block_t blk_i,
    output shannon_lpf_pkg::hist_window_t  win_o
);

    import shannon_lpf_pkg::*;

    localparam int NS = `LPF_NSAMPS;
    localparam int HB = `LPF_HIST_BLOCKS;

    hist_window_t win_q;

    ////////////////////
    // Block shift register
    ////////////////////

    // Oldest block falls off the bottom each clock
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            win_q <= '0;
        end else begin
            for (int b = 0; b < HB - 1; b++) begin
                win_q[b*NS +: NS] <= win_q[(b+1)*NS +: NS];
            end
            // Newest block lands on top
            win_q[(HB-1)*NS +: NS] <= blk_i;
        end
    end

    assign win_o = win_q;

endmodule

`default_nettype wire

//--- hw/symmetric_preadd.sv
`timescale 1ns/1ps
`default_nettype none

`include "shannon_lpf_settings.svh"

module symmetric_preadd #(
    parameter int LANE = 0
) (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  shannon_lpf_pkg::hist_window_t win_i,
    output shannon_lpf_pkg::lane_terms_t  terms_o
);

    import shannon_lpf_pkg::*;

    // Delay span of the filter, 32 samples
    localparam int SPAN = 4 * `LPF_NPAIRS;
    // First sample of the current block in the window
    localparam int CUR  = (`LPF_HIST_BLOCKS - 1) * `LPF_NSAMPS;
    // Window position of this lane's output sample
    localparam int POS  = CUR + LANE;

    lane_terms_t terms_d;
    lane_terms_t terms_q;

    // Sign extend by one bit
    function automatic pair_sum_t widen(input sample_t s);
        widen = {s[`LPF_IN_BITS-1], s};
    endfunction

    ////////////////////
    // Pair selection
    ////////////////////

    // Lag k pairs with its mirror at SPAN-k
    always_comb begin
        for (int j = 0; j < `LPF_NPAIRS; j++) begin
            terms_d.pairs[j] = widen(win_i[POS - (2*j + 1)])
                             + widen(win_i[POS - (SPAN - (2*j + 1))]);
        end
        // Centre tap has no partner
        terms_d.centre = widen(win_i[POS - SPAN/2]);
    end

    ////////////////////
    // Pre-add register
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            terms_q <= '0;
        end else begin
            terms_q <= terms_d;
        end
    end

    assign terms_o = terms_q;

endmodule

`default_nettype wire

//--- hw/coef_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "shannon_lpf_settings.svh"

module coef_mac (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  shannon_lpf_pkg::lane_terms_t terms_i,
    output shannon_lpf_pkg::out_sample_t y_o
);

    import shannon_lpf_pkg::*;

    // Index NPAIRS carries the centre product
    product_t [`LPF_NPAIRS:0] prod_d;
    product_t [`LPF_NPAIRS:0] prod_q;
    acc_t                     acc_d;
    acc_t                     acc_q;
    acc_t                     acc_shift;
    out_sample_t              y_q;

    // Coefficient for pair j, lag 2j+1
    function automatic coef_t pair_coef(input int idx);
        case (idx)
            0:       pair_coef = coef_t'(`LPF_COEF_L1);
            1:       pair_coef = coef_t'(`LPF_COEF_L3);
            2:       pair_coef = coef_t'(`LPF_COEF_L5);
            3:       pair_coef = coef_t'(`LPF_COEF_L7);
            4:       pair_coef = coef_t'(`LPF_COEF_L9);
            5:       pair_coef = coef_t'(`LPF_COEF_L11);
            6:       pair_coef = coef_t'(`LPF_COEF_L13);
            default: pair_coef = coef_t'(`LPF_COEF_L15);
        endcase
    endfunction

    ////////////////////
    // Stage 1 multiply
    ////////////////////

    always_comb begin
        for (int j = 0; j < `LPF_NPAIRS; j++) begin
            prod_d[j] = $signed(terms_i.pairs[j]) * $signed(pair_coef(j));
        end
        prod_d[`LPF_NPAIRS] = $signed(terms_i.centre)
                            * $signed(coef_t'(`LPF_COEF_CENTRE));
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            prod_q <= '0;
        end else begin
            prod_q <= prod_d;
        end
    end

    ////////////////////
    // Stage 2 sum
    ////////////////////

    always_comb begin
        acc_d = '0;
        for (int j = 0; j <= `LPF_NPAIRS; j++) begin
            acc_d = acc_d + $signed(prod_q[j]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            acc_q <= '0;
        end else begin
            acc_q <= acc_d;
        end
    end

    ////////////////////
    // Stage 3 scale
    ////////////////////

    // Floor division by 2^15, then wrap to output width
    assign acc_shift = acc_q >>> `LPF_SHIFT;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            y_q <= '0;
        end else begin
            y_q <= acc_shift[`LPF_OUT_BITS-1:0];
        end
    end

    assign y_o = y_q;

endmodule

`default_nettype wire

//--- hw/shannon_lpf_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "shannon_lpf_settings.svh"

module shannon_lpf_top (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  shannon_lpf_pkg::sample_block_t in_i,
    output shannon_lpf_pkg::out_block_t    out_o
);

    import shannon_lpf_pkg::*;

    hist_window_t                   window;
    lane_terms_t [`LPF_NSAMPS-1:0]  terms;

    // Shared 40-sample window
    sample_history u_sample_history (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .blk_i   (in_i),
        .win_o   (window)
    );

    ////////////////////
    // Per-lane filters
    ////////////////////

    for (genvar g = 0; g < `LPF_NSAMPS; g++) begin : g_lane
        symmetric_preadd #(
            .LANE (g)
        ) u_symmetric_preadd (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .win_i   (window),
            .terms_o (terms[g])
        );

        coef_mac u_coef_mac (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .terms_i (terms[g]),
            .y_o     (out_o[g])
        );
    end

endmodule

`default_nettype wire

//--- testbench/tb_lpf_model.svh
`ifndef TB_LPF_MODEL_SVH
`define TB_LPF_MODEL_SVH

// Every sample driven since the last reset, oldest first
sample_t     hist_q[$];
logic [15:0] lfsr_state = 16'd51;

// Filter taps in Q0.15 by lag
function automatic longint lag_coef(input int k);
    case (k)
        1, 31:   return -23;
        3, 29:   return 105;
        5, 27:   return -526;
        7, 25:   return 263;
        9, 23:   return -949;
        11, 21:  return 1672;
        13, 19:  return -3216;
        15, 17:  return 10342;
        16:      return 16384;
        default: return 0;
    endcase
endfunction

// Unscaled convolution sum for sample index n
function automatic longint full_sum(input int n);
    longint acc;
    acc = 0;
    for (int k = 0; k < 32; k++) begin
        if (n - k >= 0) begin
            acc = acc + lag_coef(k) * longint'(hist_q[n-k]);
        end
    end
    return acc;
endfunction

// Floor by 2^15, then keep the low output bits
function automatic out_sample_t expected_sample(input int n);
    longint scaled;
    scaled = full_sum(n) >>> 15;
    return out_sample_t'(scaled);
endfunction

// x^16 + x^14 + x^13 + x^11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic sample_t random_sample();
    sample_t v;
    v = '0;
    for (int b = 0; b < 12; b++) begin
        lfsr_state = lfsr_step(lfsr_state);
        v = {v[10:0], lfsr_state[0]};
    end
    return v;
endfunction

task automatic check_out_sample(input int lane, input out_sample_t exp_v,
                                input out_sample_t act_v);
    checks_done++;
    if (act_v !== exp_v) begin
        $display("ERR %0t out_o[%0d] expected %0d got %0d", $time, lane, exp_v, act_v);
        test_errors++;
    end
endtask

`endif

//--- testbench/tb_shannon_lpf.sv
`timescale 1ns/1ps
`default_nettype none

`include "shannon_lpf_settings.svh"

module tb_shannon_lpf;

    import shannon_lpf_pkg::*;

    localparam int LATENCY = `LPF_LATENCY;
    localparam int NS      = `LPF_NSAMPS;
    // Blocks driven by all tests, reset and drain excluded
    localparam int TEST_BLOCKS = 20 + 48 + 10 + 200 + 5 + 68;

    logic          clk_i = 1'b0;
    logic          rst_n_i;
    sample_block_t in_i;
    out_block_t    out_o;

    int test_errors;
    int tests_passed;
    int tests_failed;
    int checks_done;
    int pend_q[$];
    int blk_count;

    `include "tb_lpf_model.svh"

    shannon_lpf_top u_shannon_lpf_top (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .in_i    (in_i),
        .out_o   (out_o)
    );

    always #50 clk_i = ~clk_i;

    ////////////////////
    // Drive helpers
    ////////////////////

    task automatic apply_reset();
        @(posedge clk_i);
        rst_n_i <= 1'b0;
        in_i    <= '0;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        hist_q.delete();
        pend_q.delete();
        blk_count = 0;
        @(negedge clk_i);
        // Pipeline must be clear right after reset
        for (int i = 0; i < NS; i++) check_out_sample(i, '0, out_o[i]);
    endtask

    // Output of a block shows up LATENCY edges after it is driven
    task automatic drive_block(input sample_block_t blk);
        int b;
        @(posedge clk_i);
        in_i <= blk;
        for (int i = 0; i < NS; i++) hist_q.push_back(blk[i]);
        pend_q.push_back(blk_count);
        blk_count++;
        @(negedge clk_i);
        if (pend_q.size() > LATENCY) begin
            b = pend_q.pop_front();
            for (int i = 0; i < NS; i++) begin
                check_out_sample(i, expected_sample(b*NS + i), out_o[i]);
            end
        end
    endtask

    task automatic drain();
        repeat (LATENCY) drive_block('0);
    endtask

    task automatic run_impulses();
        sample_block_t blk;
        for (int p = 0; p < NS; p++) begin
            blk    = '0;
            blk[p] = sample_t'(1000);
            drive_block(blk);
            repeat (5) drive_block('0);
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) tests_passed++;
        else tests_failed++;
        $display("test %s done, %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic test_reset_state();
        apply_reset();
        repeat (20) drive_block('0);
        drain();
        finish_test("reset_state");
    endtask

    task automatic test_impulse();
        apply_reset();
        run_impulses();
        drain();
        finish_test("impulse");
    endtask

    task automatic test_dc_gain();
        apply_reset();
        repeat (10) drive_block({NS{sample_t'(700)}});
        // Fifth block is fully settled, taps sum to 31720
        for (int i = 0; i < NS; i++) begin
            check_out_sample(i, out_sample_t'((700 * 31720) >>> 15), out_o[i]);
        end
        drain();
        finish_test("dc_gain");
    endtask

    task automatic test_random();
        sample_block_t blk;
        apply_reset();
        repeat (200) begin
            for (int i = 0; i < NS; i++) blk[i] = random_sample();
            drive_block(blk);
        end
        drain();
        finish_test("random");
    endtask

    task automatic test_wrap();
        sample_t       pat [0:39];
        sample_block_t blk;
        longint        c;
        apply_reset();
        // Target is sample 39, lane 7 of block 4
        for (int m = 0; m < 40; m++) pat[m] = '0;
        for (int k = 0; k < 32; k++) begin
            c = lag_coef(k);
            if (c > 0) pat[39-k] = sample_t'(2047);
            else if (c < 0) pat[39-k] = sample_t'(-2048);
        end
        for (int b = 0; b < 5; b++) begin
            for (int i = 0; i < NS; i++) blk[i] = pat[b*NS + i];
            drive_block(blk);
        end
        if ((full_sum(39) >>> 15) <= 2047) begin
            $display("Wrap pattern did not push the sum past the output range");
            test_errors++;
        end
        drain();
        finish_test("wrap");
    endtask

    task automatic test_reset_midstream();
        sample_block_t blk;
        apply_reset();
        repeat (20) begin
            for (int i = 0; i < NS; i++) blk[i] = random_sample();
            drive_block(blk);
        end
        // Window still full of random data when reset hits
        apply_reset();
        run_impulses();
        drain();
        finish_test("reset_midstream");
    endtask

    // Watchdog
    initial begin
        #(2 * TEST_BLOCKS * 100);
        $display("Timeout: simulation ran longer than the tests allow");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        rst_n_i      = 1'b0;
        in_i         = '0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        checks_done  = 0;
        blk_count    = 0;
        test_reset_state();
        test_impulse();
        test_dc_gain();
        test_random();
        test_wrap();
        test_reset_midstream();
        $display("Tests passed %0d failed %0d, checks %0d",
                 tests_passed, tests_failed, checks_done);
        if (tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- shannon_lpf.f
+incdir+hw
+incdir+testbench
hw/shannon_lpf_pkg.sv
hw/sample_history.sv
hw/symmetric_preadd.sv
hw/coef_mac.sv
hw/shannon_lpf_top.sv
testbench/tb_shannon_lpf.sv

//--- Makefile
TOP := tb_shannon_lpf
LOG := sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f shannon_lpf.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
